// File: bench/dcache_properties.sv
`default_nettype none

module dcache_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 cpu_req,
    input logic                 cpu_ack,
    input logic                 mem_req,
    input logic                 mem_ack,
    input dcache_pkg::mem_req_t mem_req_data
);
    timeunit 1ns;
    timeprecision 100ps;

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> !cpu_ack && !mem_req)
        else $error("cpu_ack or mem_req high after a reset cycle");

    // request held until the memory answers
    mem_data_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req && !mem_ack) |-> $stable(mem_req_data))
        else $error("mem_req_data changed during a memory request");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose without cpu_req");

endmodule

bind dcache_top dcache_properties i_props (
    .clk          (clk),
    .rst          (rst),
    .cpu_req      (cpu_req),
    .cpu_ack      (cpu_ack),
    .mem_req      (mem_req),
    .mem_ack      (mem_ack),
    .mem_req_data (mem_req_data)
);

`default_nettype wire

// File: bench/mem_model.sv
`default_nettype none

module mem_model #(
    parameter logic [31:0] SEED = 32'h0000_0001
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req,
    input  dcache_pkg::mem_req_t mem_req_data,
    output logic                 mem_ack,
    output dcache_pkg::word_t    mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    word_t store [word_t];
    int    writes [word_t];
    int    reads [word_t];
    word_t rng;
    logic  busy;
    int    wait_cnt;

    function automatic word_t step_rng(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched words hold their own address xor a fixed pattern
    function automatic word_t peek(word_t a);
        if (store.exists(a)) return store[a];
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic int write_count(word_t a);
        if (writes.exists(a)) return writes[a];
        return 0;
    endfunction

    function automatic int read_count(word_t a);
        if (reads.exists(a)) return reads[a];
        return 0;
    endfunction

    function automatic logic in_dead_region(word_t a);
        return a[19:8] == 12'hfff;
    endfunction

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        wait_cnt  = 0;
        rng       = SEED;
        forever begin
            @(posedge clk);
            #2;
            if (rst) begin
                mem_ack = 1'b0;
                busy    = 1'b0;
            end else if (mem_ack) begin
                if (!mem_req) begin
                    mem_ack = 1'b0;
                    busy    = 1'b0;
                end
            end else if (!mem_req) begin
                busy = 1'b0;
            end else if (!busy) begin
                busy     = 1'b1;
                rng      = step_rng(rng);
                wait_cnt = 1 + int'(rng % 3);
            end else if (!in_dead_region(mem_req_data.addr)) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    if (mem_req_data.write) begin
                        store[mem_req_data.addr]  = mem_req_data.wdata;
                        writes[mem_req_data.addr] = write_count(mem_req_data.addr) + 1;
                    end else begin
                        mem_rdata                = peek(mem_req_data.addr);
                        reads[mem_req_data.addr] = read_count(mem_req_data.addr) + 1;
                    end
                    mem_ack = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_dcache.sv
`default_nettype none

module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam word_t SEED         = 32'hb42328e8;
    localparam int    ACCESS_LIMIT = 200;
    localparam int    DROP_LIMIT   = 10;

    logic      clk;
    logic      rst;
    logic      cpu_req;
    cpu_req_t  cpu_req_data;
    logic      cpu_ack;
    cpu_resp_t cpu_resp;
    logic      mem_req;
    mem_req_t  mem_req_data;
    logic      mem_ack;
    word_t     mem_rdata;

    word_t rng_state;
    word_t ref_mem [word_t];
    int    errors;
    int    test_errors;
    int    checks;
    int    tests;

    dcache_top #(
        .INDEX_BITS     (10),
        .TIMEOUT_CYCLES (16)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_req_data (cpu_req_data),
        .cpu_ack      (cpu_ack),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    mem_model #(
        .SEED (SEED)
    ) i_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // keeps tag bit 19 clear, so never in the i/o space
    function automatic word_t random_cached_addr();
        return next_rand() & 32'h0007_fffc;
    endfunction

    function automatic word_t ref_read(word_t a);
        word_t w;
        w = {a[31:2], 2'b00};
        if (ref_mem.exists(w)) return ref_mem[w];
        return w ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t expect_load(ldst_op_t op, word_t addr, word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * int'(addr[1:0])));
        h = 16'(w >> (16 * int'(addr[1])));
        case (op)
            LW:      return w;
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0000, h};
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h000000, b};
            default: return '0;
        endcase
    endfunction

    function automatic word_t merge_store(ldst_op_t op, word_t addr, word_t old, word_t wdata);
        word_t mask;
        int    sh;
        case (op)
            SH: begin
                sh   = 16 * int'(addr[1]);
                mask = 32'h0000_ffff << sh;
            end
            SB: begin
                sh   = 8 * int'(addr[1:0]);
                mask = 32'h0000_00ff << sh;
            end
            default: begin
                sh   = 0;
                mask = 32'hffff_ffff;
            end
        endcase
        return (old & ~mask) | ((wdata << sh) & mask);
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_err(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected err %b, actual err %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        checks++;
        if (exp != act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    // one full four-phase access; entered and left 2 ns after an edge
    task automatic cpu_access(input ldst_op_t op, input word_t addr, input word_t wdata,
                              output word_t rdata, output logic err,
                              output int latency, output logic mem_used);
        int   n;
        logic done;
        rdata        = '0;
        err          = 1'b1;
        latency      = 0;
        mem_used     = 1'b0;
        n            = 0;
        done         = 1'b0;
        cpu_req_data = '{addr: addr, wdata: wdata, op: op};
        cpu_req      = 1'b1;
        while (!done && n < ACCESS_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
            if (mem_req) mem_used = 1'b1;
            if (cpu_ack) done = 1'b1;
        end
        cpu_req = 1'b0;
        if (!done) begin
            $display("no cpu_ack for %s to %08h within %0d cycles", op.name(), addr,
                     ACCESS_LIMIT);
            test_errors++;
            return;
        end
        latency = n - 1;
        rdata   = cpu_resp.rdata;
        err     = cpu_resp.err;
        n       = 0;
        while (cpu_ack && n < DROP_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (cpu_ack) begin
            $display("cpu_ack stayed high after cpu_req dropped (%08h)", addr);
            test_errors++;
        end
    endtask

    task automatic load_and_check(string name, ldst_op_t op, word_t addr);
        word_t r;
        logic  e;
        int    lat;
        logic  used;
        cpu_access(op, addr, '0, r, e, lat, used);
        check_err(name, 1'b0, e);
        check_word(name, expect_load(op, addr, ref_read(addr)), r);
    endtask

    task automatic store_and_update(string name, ldst_op_t op, word_t addr, word_t wdata);
        word_t r;
        logic  e;
        int    lat;
        logic  used;
        cpu_access(op, addr, wdata, r, e, lat, used);
        check_err(name, 1'b0, e);
        ref_mem[{addr[31:2], 2'b00}] = merge_store(op, addr, ref_read(addr), wdata);
    endtask

    task automatic end_test(string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0) $display("%s: ok", name);
        else $display("%s: failed with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic cold_load_test();
        for (int i = 0; i < 8; i++) begin
            load_and_check("cold_load", LW, random_cached_addr());
        end
        end_test("cold_load");
    endtask

    task automatic sub_word_test();
        word_t    a;
        ldst_op_t sop;
        for (int i = 0; i < 9; i++) begin
            a   = random_cached_addr() | (next_rand() & 32'h3);
            sop = (i % 3 == 0) ? SW : ((i % 3 == 1) ? SH : SB);
            if (sop == SW) a = a & ~32'h3;
            if (sop == SH) a = a & ~32'h1;
            store_and_update("sub_word_store", sop, a, next_rand());
            load_and_check("sub_word_lw", LW, a & ~32'h3);
            load_and_check("sub_word_lh", LH, a & ~32'h1);
            load_and_check("sub_word_lhu", LHU, a & ~32'h1);
            load_and_check("sub_word_lb", LB, a);
            load_and_check("sub_word_lbu", LBU, a);
        end
        end_test("sub_word");
    endtask

    task automatic hit_latency_test();
        word_t a;
        word_t r;
        logic  e;
        int    lat;
        logic  used;
        a = random_cached_addr();
        load_and_check("hit_latency_fill", LW, a);
        cpu_access(LW, a, '0, r, e, lat, used);
        check_word("hit_latency_data", ref_read(a), r);
        check_count("hit_latency_cycles", 2, lat);
        check_count("hit_latency_mem_req", 0, int'(used));
        end_test("hit_latency");
    endtask

    task automatic dirty_eviction_test();
        word_t a;
        word_t b;
        word_t d;
        int    wc;
        a  = 32'h0001_2340;
        b  = 32'h0002_2340;
        d  = next_rand();
        wc = i_mem.write_count(a);
        store_and_update("evict_store", SW, a, d);
        load_and_check("evict_other", LW, b);
        check_count("evict_writes", 1, i_mem.write_count(a) - wc);
        check_word("evict_mem_word", d, i_mem.peek(a));
        load_and_check("evict_reload", LW, a);
        end_test("dirty_eviction");
    endtask

    task automatic uncached_io_test();
        word_t a;
        word_t r;
        logic  e;
        int    lat;
        logic  used;
        int    rc;
        int    wc;
        a  = 32'h000f_0010;
        rc = i_mem.read_count(a);
        wc = i_mem.write_count(a);
        for (int i = 0; i < 2; i++) begin
            cpu_access(LW, a, '0, r, e, lat, used);
            check_err("io_load_err", 1'b0, e);
            check_word("io_load_data", 32'h5a55_0010, r);
        end
        check_count("io_reads", 2, i_mem.read_count(a) - rc);
        cpu_access(SB, a + 32'h1, 32'h1234_56a5, r, e, lat, used);
        check_err("io_store_err", 1'b0, e);
        check_count("io_writes", 1, i_mem.write_count(a) - wc);
        check_word("io_store_lane", 32'h0000_a500, i_mem.peek(a));
        end_test("uncached_io");
    endtask

    task automatic timeout_test();
        word_t r;
        logic  e;
        int    lat;
        logic  used;
        cpu_access(LW, 32'h000f_ff40, '0, r, e, lat, used);
        check_err("timeout_err", 1'b1, e);
        check_word("timeout_rdata", 32'h0000_0000, r);
        load_and_check("after_timeout", LW, random_cached_addr());
        end_test("timeout");
    endtask

    initial begin
        rst          = 1'b1;
        cpu_req      = 1'b0;
        cpu_req_data = '0;
        rng_state    = SEED;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        tests        = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        cold_load_test();
        sub_word_test();
        hit_latency_test();
        dirty_eviction_test();
        uncached_io_test();
        timeout_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -rf obj_dir log.txt
verilator --binary --timing --assert -f vlog.f --top-module tb_dcache -o sim \
    && ./obj_dir/sim > log.txt 2>&1 \
    || { echo "build or simulation failed"; cat log.txt 2>/dev/null; exit 1; }
cat log.txt
grep -q ">>> FAIL" log.txt && exit 1
grep -q ">>> PASS" log.txt || exit 1
exit 0

// File: verilog/bus_watchdog.sv
`default_nettype none

module bus_watchdog #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic arm,
    output logic timeout
);

    localparam int CNT_BITS = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_BITS-1:0] LIMIT = CNT_BITS'(TIMEOUT_CYCLES);

    logic [CNT_BITS-1:0] count;

    // cycles spent waiting on the current request
    always_ff @(posedge clk) begin
        if (rst || !arm) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // stays up until the requester drops arm
    assign timeout = arm && (count == LIMIT);

endmodule

`default_nettype wire

// File: verilog/dcache_array.sv
`default_nettype none

module dcache_array #(
    parameter int INDEX_BITS = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::word_t addr,
    input  logic              we,
    input  dcache_pkg::word_t wdata,
    input  logic              wdirty,
    output logic              hit,
    output logic              dirty,
    output dcache_pkg::word_t victim_tag_addr,
    output dcache_pkg::word_t stored_word
);
    import dcache_pkg::*;

    // 20-bit physical space, rest of addr is ignored
    localparam int ADDR_BITS = 20;
    localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - 2;
    localparam int DEPTH     = 1 << INDEX_BITS;

    logic [DEPTH-1:0]    valid_bits;
    logic [DEPTH-1:0]    dirty_bits;
    logic [TAG_BITS-1:0] tags [DEPTH];
    word_t               data_mem [DEPTH];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   req_tag;

    logic                  rd_valid;
    logic                  rd_dirty;
    logic [TAG_BITS-1:0]   rd_tag;
    logic [TAG_BITS-1:0]   rd_req_tag;
    logic [INDEX_BITS-1:0] rd_index;
    word_t                 rd_word;

    assign index   = addr[INDEX_BITS+1:2];
    assign req_tag = addr[ADDR_BITS-1:INDEX_BITS+2];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                tags[i] <= '0;
            end
        end else if (we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= wdirty;
            tags[index]       <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            data_mem[index] <= wdata;
        end
    end

    // synchronous read, compared one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_dirty <= 1'b0;
        end else begin
            rd_valid <= valid_bits[index];
            rd_dirty <= dirty_bits[index];
        end
    end

    always_ff @(posedge clk) begin
        rd_tag     <= tags[index];
        rd_req_tag <= req_tag;
        rd_index   <= index;
        rd_word    <= data_mem[index];
    end

    assign hit             = rd_valid && (rd_tag == rd_req_tag);
    assign dirty           = rd_valid && rd_dirty;
    assign victim_tag_addr = {{(32 - ADDR_BITS){1'b0}}, rd_tag, rd_index, 2'b00};
    assign stored_word     = rd_word;

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  dcache_pkg::cpu_req_t  cpu_req_data,
    output logic                  cpu_ack,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output logic                  mem_req,
    output dcache_pkg::mem_req_t  mem_req_data,
    input  logic                  mem_ack,
    input  dcache_pkg::word_t     mem_rdata,
    output dcache_pkg::word_t     arr_index_addr,
    output logic                  arr_we,
    output dcache_pkg::word_t     arr_wdata,
    output logic                  arr_dirty,
    input  logic                  hit,
    input  logic                  dirty,
    input  dcache_pkg::word_t     victim_tag_addr,
    input  dcache_pkg::word_t     stored_word,
    output dcache_pkg::ldst_op_t  align_op,
    output dcache_pkg::word_t     align_addr,
    output dcache_pkg::word_t     align_wdata,
    output dcache_pkg::word_t     align_src,
    input  dcache_pkg::word_t     load_result,
    input  dcache_pkg::word_t     store_word,
    output logic                  wd_arm,
    input  logic                  timeout
);
    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    cpu_req_t    req_q;
    cpu_resp_t   resp_q;
    logic        is_store;
    logic        uncached;
    word_t       line_addr;
    word_t       load_data;

    assign is_store  = (req_q.op == SW) || (req_q.op == SH) || (req_q.op == SB);
    assign uncached  = (req_q.addr[19:16] == 4'hf);
    assign line_addr = {req_q.addr[31:2], 2'b00};
    assign load_data = is_store ? '0 : load_result;

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (cpu_req) state_next = LOOKUP;
            end
            LOOKUP: begin
                if (uncached) state_next = IO_REQ;
                else if (hit) state_next = RESPOND;
                else if (dirty) state_next = WB_REQ;
                else state_next = FILL_REQ;
            end
            // an ack wins over a timeout seen on the same edge
            WB_REQ: begin
                if (mem_ack) state_next = WB_DROP;
                else if (timeout) state_next = RESPOND;
            end
            WB_DROP: begin
                if (!mem_ack) state_next = FILL_REQ;
            end
            FILL_REQ: begin
                if (mem_ack) state_next = FILL_DROP;
                else if (timeout) state_next = RESPOND;
            end
            FILL_DROP: begin
                if (!mem_ack) state_next = RESPOND;
            end
            IO_REQ: begin
                if (mem_ack) state_next = IO_DROP;
                else if (timeout) state_next = RESPOND;
            end
            IO_DROP: begin
                if (!mem_ack) state_next = RESPOND;
            end
            RESPOND: begin
                if (cpu_ack && !cpu_req) state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            cpu_ack <= 1'b0;
        end else begin
            state   <= state_next;
            cpu_ack <= (state == RESPOND) && cpu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req) begin
            req_q <= cpu_req_data;
        end
        case (state)
            LOOKUP: begin
                if (!uncached && hit) resp_q <= '{rdata: load_data, err: 1'b0};
            end
            FILL_REQ, IO_REQ: begin
                if (mem_ack) resp_q <= '{rdata: load_data, err: 1'b0};
                else if (timeout) resp_q <= '{rdata: '0, err: 1'b1};
            end
            WB_REQ: begin
                if (!mem_ack && timeout) resp_q <= '{rdata: '0, err: 1'b1};
            end
            default: ;
        endcase
    end

    assign cpu_resp = resp_q;
    assign mem_req  = (state == WB_REQ) || (state == FILL_REQ) || (state == IO_REQ);
    assign wd_arm   = mem_req;

    // writeback uses the victim, io stores carry the lane-shifted data
    always_comb begin
        mem_req_data = '{addr: line_addr, wdata: '0, write: 1'b0};
        if (state == WB_REQ) begin
            mem_req_data = '{addr: victim_tag_addr, wdata: stored_word, write: 1'b1};
        end else if (state == IO_REQ && is_store) begin
            mem_req_data = '{addr: line_addr, wdata: store_word, write: 1'b1};
        end
    end

    always_comb begin
        case (state)
            FILL_REQ: align_src = mem_rdata;
            IO_REQ:   align_src = is_store ? '0 : mem_rdata;
            default:  align_src = stored_word;
        endcase
    end

    assign align_op    = req_q.op;
    assign align_addr  = req_q.addr;
    assign align_wdata = req_q.wdata;

    // read index follows the cpu in IDLE so the array read lines up with capture
    assign arr_index_addr = (state == IDLE) ? cpu_req_data.addr : req_q.addr;
    assign arr_we    = (state == LOOKUP && !uncached && hit && is_store)
                    || (state == FILL_REQ && mem_ack);
    assign arr_wdata = is_store ? store_word : mem_rdata;
    assign arr_dirty = is_store;

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address or data word
    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB
    } ldst_op_t;

    // one access from the cpu
    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        ldst_op_t op;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  err;
    } cpu_resp_t;

    // one transfer on the memory bus
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_DROP,
        FILL_REQ,
        FILL_DROP,
        IO_REQ,
        IO_DROP,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/dcache_top.sv
`default_nettype none

module dcache_top #(
    parameter int INDEX_BITS     = 10,
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  dcache_pkg::cpu_req_t  cpu_req_data,
    output logic                  cpu_ack,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output logic                  mem_req,
    output dcache_pkg::mem_req_t  mem_req_data,
    input  logic                  mem_ack,
    input  dcache_pkg::word_t     mem_rdata
);
    import dcache_pkg::*;

    word_t    arr_index_addr;
    logic     arr_we;
    word_t    arr_wdata;
    logic     arr_dirty;
    logic     hit;
    logic     dirty;
    word_t    victim_tag_addr;
    word_t    stored_word;
    ldst_op_t align_op;
    word_t    align_addr;
    word_t    align_wdata;
    word_t    align_src;
    word_t    load_result;
    word_t    store_word;
    logic     wd_arm;
    logic     timeout;

    dcache_ctrl i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .cpu_req_data    (cpu_req_data),
        .cpu_ack         (cpu_ack),
        .cpu_resp        (cpu_resp),
        .mem_req         (mem_req),
        .mem_req_data    (mem_req_data),
        .mem_ack         (mem_ack),
        .mem_rdata       (mem_rdata),
        .arr_index_addr  (arr_index_addr),
        .arr_we          (arr_we),
        .arr_wdata       (arr_wdata),
        .arr_dirty       (arr_dirty),
        .hit             (hit),
        .dirty           (dirty),
        .victim_tag_addr (victim_tag_addr),
        .stored_word     (stored_word),
        .align_op        (align_op),
        .align_addr      (align_addr),
        .align_wdata     (align_wdata),
        .align_src       (align_src),
        .load_result     (load_result),
        .store_word      (store_word),
        .wd_arm          (wd_arm),
        .timeout         (timeout)
    );

    bus_watchdog #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_watchdog (
        .clk     (clk),
        .rst     (rst),
        .arm     (wd_arm),
        .timeout (timeout)
    );

    dcache_array #(
        .INDEX_BITS (INDEX_BITS)
    ) i_array (
        .clk             (clk),
        .rst             (rst),
        .addr            (arr_index_addr),
        .we              (arr_we),
        .wdata           (arr_wdata),
        .wdirty          (arr_dirty),
        .hit             (hit),
        .dirty           (dirty),
        .victim_tag_addr (victim_tag_addr),
        .stored_word     (stored_word)
    );

    load_store_align i_align (
        .op          (align_op),
        .addr        (align_addr),
        .wdata       (align_wdata),
        .src         (align_src),
        .load_result (load_result),
        .store_word  (store_word)
    );

endmodule

`default_nettype wire

// File: verilog/load_store_align.sv
`default_nettype none

module load_store_align (
    input  dcache_pkg::ldst_op_t op,
    input  dcache_pkg::word_t    addr,
    input  dcache_pkg::word_t    wdata,
    input  dcache_pkg::word_t    src,
    output dcache_pkg::word_t    load_result,
    output dcache_pkg::word_t    store_word
);
    import dcache_pkg::*;

    logic [4:0]  byte_base;
    logic [4:0]  half_base;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // bit offsets of the addressed lane
    assign byte_base = {addr[1:0], 3'b000};
    assign half_base = {addr[1], 4'b0000};

    assign lane_b = src[byte_base +: 8];
    assign lane_h = src[half_base +: 16];

    always_comb begin
        unique case (op)
            LW: begin
                load_result = src;
            end
            LH: begin
                load_result = {{16{lane_h[15]}}, lane_h};
            end
            LHU: begin
                load_result = {16'h0000, lane_h};
            end
            LB: begin
                load_result = {{24{lane_b[7]}}, lane_b};
            end
            LBU: begin
                load_result = {24'h000000, lane_b};
            end
            default: begin
                load_result = src;
            end
        endcase
    end

    // sub-word stores keep the other lanes of src
    always_comb begin
        store_word = src;
        unique case (op)
            SW: begin
                store_word = wdata;
            end
            SH: begin
                store_word[half_base +: 16] = wdata[15:0];
            end
            SB: begin
                store_word[byte_base +: 8] = wdata[7:0];
            end
            default: begin
                store_word = src;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/dcache_pkg.sv
verilog/bus_watchdog.sv
verilog/dcache_array.sv
verilog/load_store_align.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/mem_model.sv
bench/dcache_properties.sv
bench/tb_dcache.sv
